// File: Makefile
TOP := fp_unit_tb
LOG := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f tb.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f tb.f --top-module $(TOP)
	./obj_dir/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "FAIL: see errors above" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "PASS: all tests" $(LOG); then echo "Simulation did not finish"; exit 1; fi

clean:
	rm -rf obj_dir $(LOG)

// File: design/fp_addsub.sv
module fp_addsub (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      go,
    input  logic                      sub,
    input  logic [fp_pkg::WORD_W-1:0] a,
    input  logic [fp_pkg::WORD_W-1:0] b,
    output logic [fp_pkg::WORD_W-1:0] result,
    output logic                      done
);

    localparam int MANT_W = fp_pkg::FRAC_W + 1;

    fp_pkg::addsub_state_e state;

    logic [fp_pkg::WORD_W-1:0] a_r;
    logic [fp_pkg::WORD_W-1:0] b_r;
    logic [fp_pkg::EXP_W-1:0]  exp_a;
    logic [fp_pkg::EXP_W-1:0]  exp_b;
    logic [fp_pkg::EXP_W-1:0]  shift;
    logic [MANT_W-1:0]         frac_a;
    logic [MANT_W-1:0]         frac_b;
    logic signed [MANT_W+1:0]  al_a;     // Aligned mantissas with carry and sign room
    logic signed [MANT_W+1:0]  al_b;
    logic signed [MANT_W+1:0]  sum;
    logic signed [MANT_W+1:0]  neg_sum;
    logic                      sum_sign;
    logic                      sign;
    logic [fp_pkg::EXP_W-1:0]  exp;
    logic [MANT_W:0]           mag;      // Bit 24 holds the carry, bit 23 the hidden one

    assign exp_a = a_r[fp_pkg::WORD_W-2 -: fp_pkg::EXP_W];
    assign exp_b = b_r[fp_pkg::WORD_W-2 -: fp_pkg::EXP_W];
    assign frac_a = (exp_a == '0) ? '0 : {1'b1, a_r[fp_pkg::FRAC_W-1:0]};
    assign frac_b = (exp_b == '0) ? '0 : {1'b1, b_r[fp_pkg::FRAC_W-1:0]};
    assign shift = (exp_a > exp_b) ? exp_a - exp_b : exp_b - exp_a;

    assign sum = al_a + al_b;
    assign neg_sum = -sum;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= fp_pkg::S_IDLE;
            sign <= 1'b0;
            exp <= '0;
            mag <= '0;
        end else begin
            case (state)
                fp_pkg::S_IDLE: begin
                    if (go) begin
                        a_r <= a;
                        b_r <= {b[fp_pkg::WORD_W-1] ^ sub, b[fp_pkg::WORD_W-2:0]};
                        state <= fp_pkg::S_ALIGN;
                    end
                end
                fp_pkg::S_ALIGN: begin
                    if (exp_a > exp_b) begin
                        al_a <= {2'b00, frac_a};
                        al_b <= {2'b00, frac_b >> shift};
                        exp <= exp_a;
                    end else begin
                        al_a <= {2'b00, frac_a >> shift};
                        al_b <= {2'b00, frac_b};
                        exp <= exp_b;
                    end
                    state <= fp_pkg::S_SIGN;
                end
                fp_pkg::S_SIGN: begin
                    if (a_r[fp_pkg::WORD_W-1] == b_r[fp_pkg::WORD_W-1]) begin
                        sum_sign <= a_r[fp_pkg::WORD_W-1];
                    end else if (a_r[fp_pkg::WORD_W-1]) begin
                        // Negative a becomes the subtrahend
                        al_a <= al_b;
                        al_b <= -al_a;
                        sum_sign <= 1'b0;
                    end else begin
                        al_b <= -al_b;
                        sum_sign <= 1'b0;
                    end
                    state <= fp_pkg::S_SUM;
                end
                fp_pkg::S_SUM: begin
                    if (sum[MANT_W+1]) begin
                        sign <= 1'b1;
                        mag <= neg_sum[MANT_W:0];
                    end else begin
                        sign <= sum_sign;
                        mag <= sum[MANT_W:0];
                    end
                    state <= fp_pkg::S_NORM;
                end
                default: begin
                    if (mag[MANT_W]) begin
                        mag <= mag >> 1;
                        exp <= exp + 8'd1;
                        state <= fp_pkg::S_IDLE;
                    end else if (mag == '0) begin
                        sign <= 1'b0;   // Full cancellation is +0
                        exp <= '0;
                        state <= fp_pkg::S_IDLE;
                    end else if (!mag[MANT_W-1]) begin
                        mag <= mag << 1;  // One position per cycle
                        exp <= exp - 8'd1;
                    end else begin
                        state <= fp_pkg::S_IDLE;
                    end
                end
            endcase
        end
    end

    assign result = {sign, exp, mag[fp_pkg::FRAC_W-1:0]};
    assign done = state == fp_pkg::S_IDLE;

endmodule

// File: design/fp_mul.sv
module fp_mul #(
    parameter int MUL_BITS = 8
) (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      go,
    input  logic [fp_pkg::WORD_W-1:0] a,
    input  logic [fp_pkg::WORD_W-1:0] b,
    output logic [fp_pkg::WORD_W-1:0] result,
    output logic                      done
);

    localparam int MANT_W = fp_pkg::FRAC_W + 1;

    fp_pkg::mul_state_e state;

    logic [fp_pkg::WORD_W-1:0] a_r;
    logic [fp_pkg::WORD_W-1:0] b_r;
    logic                      sign;
    logic [fp_pkg::EXP_W-1:0]  exp;
    logic [2*MANT_W-1:0]       product;
    logic [2*MANT_W-1:0]       mul_product;
    logic                      mul_done;
    logic [fp_pkg::EXP_W-1:0]  exp_a;
    logic [fp_pkg::EXP_W-1:0]  exp_b;
    logic [MANT_W-1:0]         frac_a;
    logic [MANT_W-1:0]         frac_b;

    assign exp_a = a_r[fp_pkg::WORD_W-2 -: fp_pkg::EXP_W];
    assign exp_b = b_r[fp_pkg::WORD_W-2 -: fp_pkg::EXP_W];
    assign frac_a = (exp_a == '0) ? '0 : {1'b1, a_r[fp_pkg::FRAC_W-1:0]};
    assign frac_b = (exp_b == '0) ? '0 : {1'b1, b_r[fp_pkg::FRAC_W-1:0]};

    mul_iter #(.MUL_BITS(MUL_BITS)) mul_iter_inst (
        .clk     (clk),
        .start   (state == fp_pkg::M_SETUP),
        .x       (frac_a),
        .y       (frac_b),
        .product (mul_product),
        .done    (mul_done)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= fp_pkg::M_IDLE;
            sign <= 1'b0;
            exp <= '0;
            product <= '0;
        end else begin
            case (state)
                fp_pkg::M_IDLE: begin
                    if (go) begin
                        a_r <= a;
                        b_r <= b;
                        state <= fp_pkg::M_SETUP;
                    end
                end
                fp_pkg::M_SETUP: begin
                    sign <= a_r[fp_pkg::WORD_W-1] ^ b_r[fp_pkg::WORD_W-1];
                    exp <= exp_a + exp_b;  // Wraps, the bias comes off later
                    state <= fp_pkg::M_MULT;
                end
                fp_pkg::M_MULT: begin
                    if (mul_done) begin
                        product <= mul_product;
                        // Assume a product of 2 or more, norm fixes the other case
                        exp <= exp - fp_pkg::EXP_BIAS + 8'd1;
                        state <= fp_pkg::M_NORM;
                    end
                end
                default: begin
                    if (!product[2*MANT_W-1]) begin
                        if (product == '0) begin
                            sign <= 1'b0;
                            exp <= '0;
                        end else begin
                            product <= product << 1;
                            exp <= exp - 8'd1;
                        end
                    end
                    state <= fp_pkg::M_IDLE;
                end
            endcase
        end
    end

    assign result = {sign, exp, product[2*MANT_W-2 -: fp_pkg::FRAC_W]};
    assign done = state == fp_pkg::M_IDLE;

endmodule

// File: design/fp_pkg.sv
package fp_pkg;

    // binary32 field layout
    localparam int WORD_W = 32;
    localparam int EXP_W = 8;
    localparam int FRAC_W = 23;   // Hidden bit not stored

    localparam logic [EXP_W-1:0] EXP_BIAS = 8'd127;

    typedef enum logic [1:0] {
        OP_ADD,
        OP_SUB,
        OP_MUL,
        OP_ITOF
    } op_e;

    typedef enum logic [2:0] {
        S_IDLE,
        S_ALIGN,
        S_SIGN,
        S_SUM,
        S_NORM
    } addsub_state_e;

    typedef enum logic [1:0] {
        M_IDLE,
        M_SETUP,
        M_MULT,
        M_NORM
    } mul_state_e;

endpackage

// File: design/fp_unit.sv
module fp_unit #(
    parameter int MUL_BITS = 8
) (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      start,
    input  fp_pkg::op_e               op,
    input  logic [fp_pkg::WORD_W-1:0] a,
    input  logic [fp_pkg::WORD_W-1:0] b,
    output logic [fp_pkg::WORD_W-1:0] result,
    output logic                      ready
);

    fp_pkg::op_e op_r;

    logic                      accept;
    logic                      go_add;
    logic                      go_mul;
    logic                      add_done;
    logic                      mul_done;
    logic                      itof_busy;
    logic [fp_pkg::WORD_W-1:0] add_result;
    logic [fp_pkg::WORD_W-1:0] mul_result;
    logic [fp_pkg::WORD_W-1:0] itof_f;
    logic [fp_pkg::WORD_W-1:0] itof_r;

    assign accept = start && ready;  // Starts while busy are dropped
    assign go_add = accept && (op == fp_pkg::OP_ADD || op == fp_pkg::OP_SUB);
    assign go_mul = accept && op == fp_pkg::OP_MUL;

    fp_addsub fp_addsub_inst (
        .clk    (clk),
        .rst    (rst),
        .go     (go_add),
        .sub    (op == fp_pkg::OP_SUB),
        .a      (a),
        .b      (b),
        .result (add_result),
        .done   (add_done)
    );

    fp_mul #(.MUL_BITS(MUL_BITS)) fp_mul_inst (
        .clk    (clk),
        .rst    (rst),
        .go     (go_mul),
        .a      (a),
        .b      (b),
        .result (mul_result),
        .done   (mul_done)
    );

    int_to_float int_to_float_inst (
        .a (a),
        .f (itof_f)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            op_r <= fp_pkg::OP_ADD;
            itof_busy <= 1'b0;
        end else begin
            if (accept) begin
                op_r <= op;
            end
            // Conversion is combinational, one busy cycle keeps the protocol uniform
            itof_busy <= accept && op == fp_pkg::OP_ITOF;
        end
    end

    always_ff @(posedge clk) begin
        if (accept && op == fp_pkg::OP_ITOF) begin
            itof_r <= itof_f;
        end
    end

    always_comb begin
        case (op_r)
            fp_pkg::OP_MUL: begin
                result = mul_result;
                ready = mul_done;
            end
            fp_pkg::OP_ITOF: begin
                result = itof_r;
                ready = !itof_busy;
            end
            default: begin
                result = add_result;
                ready = add_done;
            end
        endcase
    end

endmodule

// File: design/int_to_float.sv
module int_to_float (
    input  logic [fp_pkg::WORD_W-1:0] a,
    output logic [fp_pkg::WORD_W-1:0] f
);

    logic [fp_pkg::WORD_W-1:0] mag;
    logic [fp_pkg::WORD_W-1:0] norm;
    logic [4:0]                lz;      // Leading zeros of the magnitude
    logic [fp_pkg::EXP_W-1:0]  exp;

    assign mag = a[fp_pkg::WORD_W-1] ? -a : a;

    always_comb begin
        lz = '0;
        // The highest set bit is written last and decides the count
        for (int i = 0; i < fp_pkg::WORD_W; i++) begin
            if (mag[i]) begin
                lz = 5'(fp_pkg::WORD_W - 1 - i);
            end
        end
    end

    assign norm = mag << lz;  // Leading one lands in bit 31
    assign exp = fp_pkg::EXP_BIAS + {3'b000, 5'd31 - lz};

    always_comb begin
        if (a == '0) begin
            f = '0;
        end else begin
            f = {a[fp_pkg::WORD_W-1], exp, norm[fp_pkg::WORD_W-2 -: fp_pkg::FRAC_W]};
        end
    end

endmodule

// File: design/mul_iter.sv
module mul_iter #(
    parameter int MUL_BITS = 8
) (
    input  logic                      clk,
    input  logic                      start,
    input  logic [fp_pkg::FRAC_W:0]   x,
    input  logic [fp_pkg::FRAC_W:0]   y,
    output logic [2*fp_pkg::FRAC_W+1:0] product,
    output logic                      done
);

    localparam int MANT_W = fp_pkg::FRAC_W + 1;
    localparam int STEPS = MANT_W / MUL_BITS;

    logic [MANT_W-1:0]   xs;
    logic [MANT_W-1:0]   ys;
    logic [2*MANT_W-1:0] partial;
    logic [4:0]          count;

    // Top slice of x times the whole of y
    assign partial = (2*MANT_W)'(ys) * (2*MANT_W)'(xs[MANT_W-1 -: MUL_BITS]);

    always_ff @(posedge clk) begin
        if (start) begin
            xs <= x;
            ys <= y;
            product <= '0;
            count <= 5'(STEPS);
        end else if (!done) begin
            product <= (product << MUL_BITS) + partial;
            xs <= xs << MUL_BITS;
            count <= count - 5'd1;
        end
    end

    assign done = count == 5'd0;

endmodule

// File: sim/fp_unit_assertions.sv
module fp_unit_assertions (
    input logic                      clk,
    input logic                      rst,
    input logic                      start,
    input logic                      ready,
    input logic [fp_pkg::WORD_W-1:0] result
);

    timeunit 1ns;
    timeprecision 1ps;

    // Out of reset no unit may be busy
    ready_after_reset: assert property (@(posedge clk) $fell(rst) |-> ready)
        else $error("ready low in the first cycle after reset");

    start_drops_ready: assert property (@(posedge clk) disable iff (rst)
        start && ready |=> !ready)
        else $error("ready stayed high after an accepted start");

    // The answer waits unchanged until the next accepted start
    result_held: assert property (@(posedge clk) disable iff (rst)
        ready && !start |=> $stable(result))
        else $error("result changed while the unit was idle");

endmodule

bind fp_unit fp_unit_assertions fp_unit_assertions_inst (
    .clk    (clk),
    .rst    (rst),
    .start  (start),
    .ready  (ready),
    .result (result)
);

// File: sim/fp_unit_tb.sv
module fp_unit_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_TESTS = 21;
    localparam int CYCLE_LIMIT = NUM_TESTS * 64 + 100;
    localparam logic [31:0] BUSY_A = 32'h42C80000;  // 100.0
    localparam logic [31:0] BUSY_B = 32'h41200000;  // 10.0

    typedef struct packed {
        fp_pkg::op_e op;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] expected;
        logic        busy_start;  // Second start while busy with another opcode and operands
        logic [2:0]  hold;        // Idle cycles to watch once ready is back
    } test_t;

    logic        clk;
    logic        rst;
    logic        start;
    fp_pkg::op_e op;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] result;
    logic        ready;

    test_t tests [NUM_TESTS];
    int    error_count;
    int    pass_count;
    int    fail_count;
    int    cycle_count = 0;

    fp_unit #(.MUL_BITS(8)) fp_unit_inst (
        .clk    (clk),
        .rst    (rst),
        .start  (start),
        .op     (op),
        .a      (a),
        .b      (b),
        .result (result),
        .ready  (ready)
    );

    initial clk = 1'b0;
    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Timeout after %0d cycles, ready never came back", cycle_count);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    task automatic load_table();
        // Addition, including alignment and a carry out of the hidden bit
        tests[0] = '{fp_pkg::OP_ADD, 32'h3FC00000, 32'h40100000, 32'h40700000, 1'b0, 3'd3};
        tests[1] = '{fp_pkg::OP_ADD, 32'h44800000, 32'h3F000000, 32'h44801000, 1'b0, 3'd0};
        tests[2] = '{fp_pkg::OP_ADD, 32'h3FC00000, 32'h3FC00000, 32'h40400000, 1'b0, 3'd0};
        // Subtraction, sign swap and cancellation
        tests[3] = '{fp_pkg::OP_SUB, 32'h40A00000, 32'h40E00000, 32'hC0000000, 1'b0, 3'd0};
        tests[4] = '{fp_pkg::OP_ADD, 32'hC0A00000, 32'h40400000, 32'hC0000000, 1'b0, 3'd0};
        tests[5] = '{fp_pkg::OP_SUB, 32'h40400000, 32'h40400000, 32'h00000000, 1'b0, 3'd3};
        tests[6] = '{fp_pkg::OP_SUB, 32'h3F800000, 32'h3F700000, 32'h3D800000, 1'b0, 3'd0};
        // Multiplication, zero exponents read as zero
        tests[7] = '{fp_pkg::OP_MUL, 32'h40400000, 32'hC0200000, 32'hC0F00000, 1'b0, 3'd2};
        tests[8] = '{fp_pkg::OP_MUL, 32'h3F000000, 32'h3F000000, 32'h3E800000, 1'b0, 3'd0};
        tests[9] = '{fp_pkg::OP_MUL, 32'h80000000, 32'h40400000, 32'h00000000, 1'b0, 3'd0};
        tests[10] = '{fp_pkg::OP_MUL, 32'h40000000, 32'h00400000, 32'h00000000, 1'b0, 3'd0};
        // Integer to float
        tests[11] = '{fp_pkg::OP_ITOF, 32'h00000000, 32'h0, 32'h00000000, 1'b0, 3'd0};
        tests[12] = '{fp_pkg::OP_ITOF, 32'h00000001, 32'h0, 32'h3F800000, 1'b0, 3'd2};
        tests[13] = '{fp_pkg::OP_ITOF, 32'hFFFFFFFF, 32'h0, 32'hBF800000, 1'b0, 3'd0};
        tests[14] = '{fp_pkg::OP_ITOF, 32'h000003E8, 32'h0, 32'h447A0000, 1'b0, 3'd0};
        tests[15] = '{fp_pkg::OP_ITOF, 32'h80000000, 32'h0, 32'hCF000000, 1'b0, 3'd0};
        // Starts issued while busy must be dropped
        tests[16] = '{fp_pkg::OP_ADD, 32'h3FC00000, 32'h40100000, 32'h40700000, 1'b1, 3'd0};
        tests[17] = '{fp_pkg::OP_MUL, 32'h40400000, 32'hC0200000, 32'hC0F00000, 1'b1, 3'd0};
        tests[18] = '{fp_pkg::OP_SUB, 32'h40A00000, 32'h40E00000, 32'hC0000000, 1'b1, 3'd4};
        // Mixed opcodes back to back
        tests[19] = '{fp_pkg::OP_ITOF, 32'h000003E8, 32'h0, 32'h447A0000, 1'b0, 3'd0};
        tests[20] = '{fp_pkg::OP_MUL, 32'h3F000000, 32'h3F000000, 32'h3E800000, 1'b0, 3'd5};
    endtask

    function automatic string op_text(input fp_pkg::op_e code);
        case (code)
            fp_pkg::OP_ADD: return "add";
            fp_pkg::OP_SUB: return "sub";
            fp_pkg::OP_MUL: return "mul";
            default: return "itof";
        endcase
    endfunction

    task automatic check_result(input logic [31:0] expected);
        assert (result == expected) else begin
            $display("MISMATCH time=%0t signal=result expected=%h actual=%h",
                     $time, expected, result);
            error_count++;
        end
    endtask

    // One-cycle start pulse, returns 1 ns after the edge that saw it
    task automatic start_op(input fp_pkg::op_e code, input logic [31:0] a_in,
                            input logic [31:0] b_in);
        start = 1'b1;
        op = code;
        a = a_in;
        b = b_in;
        @(posedge clk);
        #1;
        start = 1'b0;
    endtask

    task automatic wait_ready(output int cycles);
        cycles = 0;
        while (!ready) begin
            @(posedge clk);
            #1;
            cycles++;
        end
    endtask

    task automatic watch_hold(input int idle_cycles, input logic [31:0] held);
        repeat (idle_cycles) begin
            @(posedge clk);
            #1;
            assert (ready) else begin
                $display("Ready dropped at time %0t with no start", $time);
                error_count++;
            end
            check_result(held);
        end
    endtask

    task automatic run_test(input int idx);
        test_t       t;
        fp_pkg::op_e busy_op;
        int          cycles;
        int          wait_cycles;
        int          errors_before;
        t = tests[idx];
        errors_before = error_count;
        cycles = 0;
        start_op(t.op, t.a, t.b);
        assert (!ready) else begin
            $display("Ready stayed high after the start of test %0d", idx);
            error_count++;
        end
        if (t.busy_start) begin
            // A wrongly accepted start of another opcode would switch units
            if (t.op == fp_pkg::OP_MUL) begin
                busy_op = fp_pkg::OP_ADD;
            end else begin
                busy_op = fp_pkg::OP_MUL;
            end
            start_op(busy_op, BUSY_A, BUSY_B);
            cycles = 1;
        end
        wait_ready(wait_cycles);
        cycles = cycles + wait_cycles;
        if (t.op == fp_pkg::OP_ITOF) begin
            assert (cycles == 1) else begin
                $display("Conversion took %0d cycles where one was expected", cycles);
                error_count++;
            end
        end
        check_result(t.expected);
        watch_hold(int'(t.hold), t.expected);
        if (error_count == errors_before) begin
            pass_count++;
            $display("test %0d %s a=%h b=%h result=%h cycles=%0d ok",
                     idx, op_text(t.op), t.a, t.b, result, cycles);
        end else begin
            fail_count++;
            $display("test %0d %s a=%h b=%h result=%h cycles=%0d failed",
                     idx, op_text(t.op), t.a, t.b, result, cycles);
        end
    endtask

    initial begin
        rst = 1'b1;
        start = 1'b0;
        op = fp_pkg::OP_ADD;
        a = '0;
        b = '0;
        error_count = 0;
        pass_count = 0;
        fail_count = 0;
        load_table();
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;
        @(posedge clk);
        #1;
        assert (ready) else begin
            $display("Ready is not high after reset");
            error_count++;
        end
        for (int i = 0; i < NUM_TESTS; i++) begin
            run_test(i);
        end
        $display("Done: %0d tests passed, %0d failed, %0d check errors",
                 pass_count, fail_count, error_count);
        if (fail_count == 0 && error_count == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// File: tb.f
design/fp_pkg.sv
design/int_to_float.sv
design/mul_iter.sv
design/fp_mul.sv
design/fp_addsub.sv
design/fp_unit.sv
sim/fp_unit_assertions.sv
sim/fp_unit_tb.sv
